//--- common/harness_pkg.sv
package harness_pkg;

    localparam int MEM_WORDS    = 256;
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    typedef logic [31:0]          word_t;
    typedef logic [7:0]           addr_t;  // Word address
    typedef logic [7:0]           byte_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    localparam bit_cnt_t BIT_LAST  = bit_cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_cnt_t HALF_LAST = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

    localparam byte_t CORE_ID   = 8'h5A;
    localparam byte_t ACK_BYTE  = 8'hA5;
    localparam byte_t HALT_BYTE = 8'hAA;

    // Held in bits 31 to 24 of an instruction word
    typedef enum logic [7:0] {
        OP_LDI  = 8'h01,
        OP_LD   = 8'h02,
        OP_ST   = 8'h03,
        OP_ADD  = 8'h04,
        OP_ADDI = 8'h05,
        OP_BNZ  = 8'h06,
        OP_JMP  = 8'h07,
        OP_HALT = 8'h08
    } opcode_t;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h01,
        CMD_READ  = 8'h02,
        CMD_RUN   = 8'h03,
        CMD_ID    = 8'h04
    } cmd_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_DATA, S_MEM, S_RUN, S_REPLY} ctrl_state_t;

    typedef enum logic [1:0] {FETCH, EXEC, MEMWAIT, HALTED} core_state_t;

endpackage

//--- controller/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic               sys_clk,
    input  logic               arst_n_i,
    input  logic               rx_i,
    output harness_pkg::byte_t data_o,
    output logic               valid_o
);

    logic [1:0]            sync_q;
    logic                  active_q;
    harness_pkg::bit_cnt_t cnt_q;
    logic [3:0]            idx_q;    // Bit slot, start is 0 and stop is 9
    logic                  valid_q;
    harness_pkg::byte_t    shift_q;

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q   <= 2'b11;
            active_q <= 1'b0;
            cnt_q    <= '0;
            idx_q    <= '0;
            valid_q  <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rx_i};
            valid_q <= 1'b0;
            if (!active_q) begin
                if (!sync_q[1]) begin  // Start bit seen
                    active_q <= 1'b1;
                    cnt_q    <= harness_pkg::HALF_LAST;
                    idx_q    <= '0;
                end
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= harness_pkg::BIT_LAST;
                idx_q <= idx_q + 1'b1;
                case (idx_q)
                    4'd0: if (sync_q[1]) active_q <= 1'b0;  // Glitch, not a start bit
                    4'd9: begin
                        if (!sync_q[1]) active_q <= 1'b0;   // Framing error
                        else cnt_q <= harness_pkg::HALF_LAST;
                    end
                    4'd10: begin
                        valid_q  <= 1'b1;
                        active_q <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge sys_clk) begin
        if (active_q && cnt_q == '0 && idx_q >= 4'd1 && idx_q <= 4'd8) begin
            shift_q <= {sync_q[1], shift_q[7:1]};
        end
    end

    assign data_o  = shift_q;
    assign valid_o = valid_q;

endmodule

//--- controller/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic               sys_clk,
    input  logic               arst_n_i,
    input  harness_pkg::byte_t data_i,
    input  logic               start_i,
    output logic               busy_o,
    output logic               tx_o
);

    logic                  busy_q;
    logic                  tx_q;
    logic [3:0]            left_q;   // Bits still queued behind the one on the line
    harness_pkg::bit_cnt_t cnt_q;
    logic [8:0]            shift_q;  // Data bits with the stop bit on top

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            tx_q   <= 1'b1;
            left_q <= '0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q <= 1'b1;
                tx_q   <= 1'b0;  // Start bit
                left_q <= 4'd9;
                cnt_q  <= harness_pkg::BIT_LAST;
            end
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (left_q == '0) begin
            busy_q <= 1'b0;      // Stop bit done
        end else begin
            tx_q   <= shift_q[0];
            left_q <= left_q - 1'b1;
            cnt_q  <= harness_pkg::BIT_LAST;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!busy_q && start_i) begin
            shift_q <= {1'b1, data_i};
        end else if (busy_q && cnt_q == '0) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    assign busy_o = busy_q;
    assign tx_o   = tx_q;

    a_no_start_busy: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        start_i |-> !busy_o);

endmodule

//--- controller/harness_mem.sv
`timescale 1ns/1ps

module harness_mem (
    input  logic                 sys_clk,
    input  logic                 arst_n_i,
    input  harness_pkg::wb_req_t instr_req_i,
    output harness_pkg::wb_rsp_t instr_rsp_o,
    input  harness_pkg::wb_req_t data_req_i,
    output harness_pkg::wb_rsp_t data_rsp_o
);

    harness_pkg::word_t mem [harness_pkg::MEM_WORDS];

    logic               i_ack_q;
    logic               d_ack_q;
    logic               i_hit;
    logic               d_hit;
    harness_pkg::word_t i_dat_q;
    harness_pkg::word_t d_dat_q;

    // First cycle of a strobe on each port
    assign i_hit = instr_req_i.cyc && instr_req_i.stb && !i_ack_q;
    assign d_hit = data_req_i.cyc && data_req_i.stb && !d_ack_q;

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            i_ack_q <= 1'b0;
            d_ack_q <= 1'b0;
        end else begin
            i_ack_q <= i_hit;
            d_ack_q <= d_hit;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (i_hit) begin
            i_dat_q <= mem[instr_req_i.adr];
        end
        if (d_hit) begin
            d_dat_q <= mem[data_req_i.adr];
            if (data_req_i.we) begin
                mem[data_req_i.adr] <= data_req_i.dat;  // Lands on the ack edge
            end
        end
    end

    assign instr_rsp_o = '{dat: i_dat_q, ack: i_ack_q};
    assign data_rsp_o  = '{dat: d_dat_q, ack: d_ack_q};

    a_stb_has_cyc: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        (instr_req_i.stb |-> instr_req_i.cyc) and (data_req_i.stb |-> data_req_i.cyc));

    a_instr_read_only: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        instr_req_i.cyc |-> !instr_req_i.we);

endmodule

//--- controller/harness_controller.sv
`timescale 1ns/1ps

module harness_controller (
    input  logic                 sys_clk,
    input  logic                 arst_n_i,
    input  logic                 uart_rx_i,
    output logic                 uart_tx_o,
    input  harness_pkg::wb_req_t core_instr_req_i,
    output harness_pkg::wb_rsp_t core_instr_rsp_o,
    input  harness_pkg::wb_req_t core_data_req_i,
    output harness_pkg::wb_rsp_t core_data_rsp_o,
    input  logic                 core_halted_i,
    output logic                 rst_core_o
);

    harness_pkg::ctrl_state_t state_q;
    harness_pkg::byte_t       rx_data;
    logic                     rx_valid;
    harness_pkg::byte_t       tx_byte_q;
    logic                     tx_start_q;
    logic                     tx_busy;
    logic                     rst_core_q;
    logic                     stb_q;     // Own master on the data port
    logic                     write_q;
    logic [1:0]               dcnt_q;
    logic [2:0]               left_q;    // Reply bytes still to send
    harness_pkg::addr_t       addr_q;
    harness_pkg::word_t       wdata_q;
    harness_pkg::word_t       reply_q;
    harness_pkg::wb_req_t     ctrl_req;
    harness_pkg::wb_req_t     mem_data_req;
    harness_pkg::wb_rsp_t     mem_data_rsp;

    uart_rx u_rx (.sys_clk, .arst_n_i, .rx_i(uart_rx_i), .data_o(rx_data), .valid_o(rx_valid));

    uart_tx u_tx (
        .sys_clk,
        .arst_n_i,
        .data_i  (tx_byte_q),
        .start_i (tx_start_q),
        .busy_o  (tx_busy),
        .tx_o    (uart_tx_o)
    );

    harness_mem u_mem (
        .sys_clk,
        .arst_n_i,
        .instr_req_i (core_instr_req_i),
        .instr_rsp_o (core_instr_rsp_o),
        .data_req_i  (mem_data_req),
        .data_rsp_o  (mem_data_rsp)
    );

    // Data port belongs to the core only while it runs
    assign ctrl_req        = '{cyc: stb_q, stb: stb_q, we: write_q, adr: addr_q, dat: wdata_q};
    assign mem_data_req    = rst_core_q ? ctrl_req : core_data_req_i;
    assign core_data_rsp_o = mem_data_rsp;
    assign rst_core_o      = rst_core_q;

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= harness_pkg::S_IDLE;
            rst_core_q <= 1'b1;
            stb_q      <= 1'b0;
            write_q    <= 1'b0;
            dcnt_q     <= '0;
            left_q     <= '0;
            reply_q    <= '0;
            tx_byte_q  <= '0;
            tx_start_q <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;
            case (state_q)
                harness_pkg::S_IDLE: if (rx_valid) begin
                    write_q <= (rx_data == harness_pkg::CMD_WRITE);
                    case (rx_data)
                        harness_pkg::CMD_WRITE,
                        harness_pkg::CMD_READ: state_q <= harness_pkg::S_ADDR;
                        harness_pkg::CMD_RUN: begin
                            rst_core_q <= 1'b0;
                            state_q    <= harness_pkg::S_RUN;
                        end
                        harness_pkg::CMD_ID: begin
                            reply_q <= {harness_pkg::CORE_ID, 24'h0};
                            left_q  <= 3'd1;
                            state_q <= harness_pkg::S_REPLY;
                        end
                        default: ;  // Unknown byte, no reply
                    endcase
                end
                harness_pkg::S_ADDR: if (rx_valid) begin
                    dcnt_q <= '0;
                    if (write_q) begin
                        state_q <= harness_pkg::S_DATA;
                    end else begin
                        stb_q   <= 1'b1;
                        state_q <= harness_pkg::S_MEM;
                    end
                end
                harness_pkg::S_DATA: if (rx_valid) begin
                    dcnt_q <= dcnt_q + 1'b1;
                    if (dcnt_q == 2'd3) begin
                        stb_q   <= 1'b1;
                        state_q <= harness_pkg::S_MEM;
                    end
                end
                harness_pkg::S_MEM: if (mem_data_rsp.ack) begin
                    stb_q   <= 1'b0;
                    reply_q <= write_q ? {harness_pkg::ACK_BYTE, 24'h0} : mem_data_rsp.dat;
                    left_q  <= write_q ? 3'd1 : 3'd4;
                    state_q <= harness_pkg::S_REPLY;
                end
                harness_pkg::S_RUN: if (core_halted_i) begin
                    rst_core_q <= 1'b1;  // Hold the core again
                    reply_q    <= {harness_pkg::HALT_BYTE, 24'h0};
                    left_q     <= 3'd1;
                    state_q    <= harness_pkg::S_REPLY;
                end
                harness_pkg::S_REPLY: if (!tx_busy && !tx_start_q) begin
                    tx_start_q <= 1'b1;
                    tx_byte_q  <= reply_q[31:24];  // MSB first
                    reply_q    <= {reply_q[23:0], 8'h00};
                    left_q     <= left_q - 1'b1;
                    if (left_q == 3'd1) state_q <= harness_pkg::S_IDLE;
                end
                default: state_q <= harness_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rx_valid && state_q == harness_pkg::S_ADDR) addr_q <= rx_data;
        if (rx_valid && state_q == harness_pkg::S_DATA) wdata_q <= {wdata_q[23:0], rx_data};
    end

    a_own_stb_in_reset: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        stb_q |-> rst_core_o);

endmodule

//--- logic/acc_core.sv
`timescale 1ns/1ps

module acc_core (
    input  logic                 sys_clk,
    input  logic                 arst_n_i,
    input  logic                 rst_core_i,
    output harness_pkg::wb_req_t instr_req_o,
    input  harness_pkg::wb_rsp_t instr_rsp_i,
    output harness_pkg::wb_req_t data_req_o,
    input  harness_pkg::wb_rsp_t data_rsp_i,
    output logic                 halted_o
);

    harness_pkg::core_state_t state_q;
    harness_pkg::addr_t       pc_q;
    harness_pkg::word_t       acc_q;
    harness_pkg::word_t       ir_q;
    harness_pkg::opcode_t     op;
    harness_pkg::addr_t       ir_addr;
    harness_pkg::word_t       imm_zx;
    harness_pkg::word_t       imm_sx;
    logic                     i_stb_q;
    logic                     d_stb_q;
    logic                     d_we_q;
    harness_pkg::addr_t       d_adr_q;
    harness_pkg::word_t       d_dat_q;

    // Instruction fields
    assign op      = harness_pkg::opcode_t'(ir_q[31:24]);
    assign ir_addr = ir_q[7:0];
    assign imm_zx  = {16'h0000, ir_q[15:0]};
    assign imm_sx  = {{16{ir_q[15]}}, ir_q[15:0]};

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= harness_pkg::FETCH;
            pc_q    <= '0;
            acc_q   <= '0;
            i_stb_q <= 1'b0;
            d_stb_q <= 1'b0;
        end else if (rst_core_i) begin  // Every run starts at address 0
            state_q <= harness_pkg::FETCH;
            pc_q    <= '0;
            acc_q   <= '0;
            i_stb_q <= 1'b0;
            d_stb_q <= 1'b0;
        end else begin
            case (state_q)
                harness_pkg::FETCH: begin
                    if (!i_stb_q) begin
                        i_stb_q <= 1'b1;
                    end else if (instr_rsp_i.ack) begin
                        i_stb_q <= 1'b0;
                        state_q <= harness_pkg::EXEC;
                    end
                end
                harness_pkg::EXEC: begin
                    state_q <= harness_pkg::FETCH;
                    pc_q    <= pc_q + 1'b1;
                    case (op)
                        harness_pkg::OP_LDI:  acc_q <= imm_zx;
                        harness_pkg::OP_ADDI: acc_q <= acc_q + imm_sx;
                        harness_pkg::OP_BNZ:  if (acc_q != '0) pc_q <= ir_addr;
                        harness_pkg::OP_JMP:  pc_q <= ir_addr;
                        harness_pkg::OP_LD,
                        harness_pkg::OP_ST,
                        harness_pkg::OP_ADD: begin
                            d_stb_q <= 1'b1;
                            state_q <= harness_pkg::MEMWAIT;
                        end
                        default: state_q <= harness_pkg::HALTED;  // OP_HALT or undefined
                    endcase
                end
                harness_pkg::MEMWAIT: if (data_rsp_i.ack) begin
                    d_stb_q <= 1'b0;
                    state_q <= harness_pkg::FETCH;
                    if (op == harness_pkg::OP_LD) begin
                        acc_q <= data_rsp_i.dat;
                    end else if (op == harness_pkg::OP_ADD) begin
                        acc_q <= acc_q + data_rsp_i.dat;
                    end
                end
                default: ;  // HALTED until the controller resets us
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == harness_pkg::FETCH && instr_rsp_i.ack) ir_q <= instr_rsp_i.dat;
        if (state_q == harness_pkg::EXEC) begin
            d_adr_q <= ir_addr;
            d_dat_q <= acc_q;
            d_we_q  <= (op == harness_pkg::OP_ST);
        end
    end

    assign instr_req_o = '{cyc: i_stb_q, stb: i_stb_q, we: 1'b0, adr: pc_q, dat: '0};
    assign data_req_o  = '{cyc: d_stb_q, stb: d_stb_q, we: d_we_q, adr: d_adr_q, dat: d_dat_q};
    assign halted_o    = (state_q == harness_pkg::HALTED);

    a_one_access: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        !(instr_req_o.stb && data_req_o.stb));

endmodule

//--- logic/harness_top.sv
`timescale 1ns/1ps

module harness_top (
    input  logic sys_clk,
    input  logic arst_n_i,
    input  logic uart_rx_i,
    output logic uart_tx_o
);

    // Core buses, instruction and data
    harness_pkg::wb_req_t instr_req;
    harness_pkg::wb_rsp_t instr_rsp;
    harness_pkg::wb_req_t data_req;
    harness_pkg::wb_rsp_t data_rsp;
    logic                 halted;
    logic                 rst_core;  // Active high, from the controller

    harness_controller u_controller (
        .sys_clk,
        .arst_n_i,
        .uart_rx_i,
        .uart_tx_o,
        .core_instr_req_i (instr_req),
        .core_instr_rsp_o (instr_rsp),
        .core_data_req_i  (data_req),
        .core_data_rsp_o  (data_rsp),
        .core_halted_i    (halted),
        .rst_core_o       (rst_core)
    );

    acc_core u_core (
        .sys_clk,
        .arst_n_i,
        .rst_core_i  (rst_core),
        .instr_req_o (instr_req),
        .instr_rsp_i (instr_rsp),
        .data_req_o  (data_req),
        .data_rsp_i  (data_rsp),
        .halted_o    (halted)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;  // 100 ns period
    end

    // Reset held for the first 2 rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #10;
        arst_n_o = 1'b1;
    end

endmodule

//--- sim/tb_harness.sv
`timescale 1ns/1ps

module tb_harness;

    localparam int N_RAND_WR    = 20;
    localparam int LOOP_LEN     = 14;
    localparam int LINE_LEN     = 16;
    localparam int UNDEF_LEN    = 7;
    localparam int N_RUNS       = 3;
    localparam int MAX_STEPS    = 200;
    localparam int STEP_CYCLES  = 8;    // Worst case per instruction
    localparam int REPLY_CYCLES = 30 * harness_pkg::CLKS_PER_BIT;
    localparam int RUN_CYCLES   = MAX_STEPS * STEP_CYCLES + REPLY_CYCLES;
    // A write is 7 bytes on the line and a read is 6
    localparam int TOTAL_BYTES  = 2 + N_RAND_WR * 13 + (LOOP_LEN + 1) * 7 + 4 * 6
                                + (LINE_LEN + 8) * 7 + 8 * 6 + 5 + (UNDEF_LEN + 1) * 7
                                + 3 * 6 + N_RUNS * 2;
    localparam int WATCHDOG_NS  = 2 * 100 * (TOTAL_BYTES * 11 * harness_pkg::CLKS_PER_BIT
                                + N_RUNS * RUN_CYCLES);

    logic               sys_clk;
    logic               arst_n;
    logic               uart_rx;
    logic               uart_tx;
    harness_pkg::word_t shadow [harness_pkg::MEM_WORDS];  // Host view of the memory
    harness_pkg::word_t prog_q [$];
    harness_pkg::byte_t rx_q [$];                         // Bytes seen on the reply line

    tb_clock i_clock (.clk_o(sys_clk), .arst_n_o(arst_n));

    harness_top i_dut (.sys_clk, .arst_n_i(arst_n), .uart_rx_i(uart_rx), .uart_tx_o(uart_tx));

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_byte(input string name, input harness_pkg::byte_t exp,
                              input harness_pkg::byte_t act);
        if (exp !== act) begin
            fail_run($sformatf("FAILED %s: expected %02h, actual %02h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input harness_pkg::word_t exp,
                              input harness_pkg::word_t act);
        if (exp !== act) begin
            fail_run($sformatf("FAILED %s: expected %08h, actual %08h", name, exp, act));
        end
    endtask

    function automatic harness_pkg::word_t instr(input harness_pkg::opcode_t op,
                                                 input logic [15:0] imm);
        return {op, 8'h00, imm};
    endfunction

    // ISA model, returns 1 when the program reached a halt
    function automatic bit ref_run(input harness_pkg::word_t init_img [harness_pkg::MEM_WORDS],
                                   output harness_pkg::word_t fin_img [harness_pkg::MEM_WORDS]);
        harness_pkg::addr_t pc;
        harness_pkg::word_t acc;
        harness_pkg::word_t ir;
        harness_pkg::addr_t adr;
        bit                 done;
        fin_img = init_img;
        pc      = '0;
        acc     = '0;
        done    = 1'b0;
        for (int step = 0; step < MAX_STEPS && !done; step++) begin
            ir  = fin_img[pc];
            adr = ir[7:0];
            pc  = pc + 8'd1;
            case (harness_pkg::opcode_t'(ir[31:24]))
                harness_pkg::OP_LDI:  acc = {16'h0000, ir[15:0]};
                harness_pkg::OP_LD:   acc = fin_img[adr];
                harness_pkg::OP_ST:   fin_img[adr] = acc;
                harness_pkg::OP_ADD:  acc = acc + fin_img[adr];
                harness_pkg::OP_ADDI: acc = acc + {{16{ir[15]}}, ir[15:0]};
                harness_pkg::OP_BNZ:  if (acc != '0) pc = adr;
                harness_pkg::OP_JMP:  pc = adr;
                default:              done = 1'b1;  // OP_HALT and undefined opcodes
            endcase
        end
        return done;
    endfunction

    // 8N1 frame plus one idle bit so the receiver realigns
    task automatic send_byte(input harness_pkg::byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            #10;
            uart_rx = frame[i];
            repeat (harness_pkg::CLKS_PER_BIT - 1) @(posedge sys_clk);
        end
        repeat (harness_pkg::CLKS_PER_BIT) @(posedge sys_clk);
    endtask

    task automatic get_byte(output harness_pkg::byte_t b, output bit got, input int max_cycles);
        int n;
        n   = 0;
        got = 1'b0;
        b   = '0;
        while (rx_q.size() == 0 && n < max_cycles) begin
            @(negedge sys_clk);
            n++;
        end
        if (rx_q.size() != 0) begin
            b   = rx_q.pop_front();
            got = 1'b1;
        end
    endtask

    task automatic expect_reply(input string name, input harness_pkg::byte_t exp,
                                input int max_cycles);
        harness_pkg::byte_t b;
        bit                 got;
        get_byte(b, got, max_cycles);
        if (!got) fail_run($sformatf("%s: the DUT sent no reply byte", name));
        else check_byte(name, exp, b);
    endtask

    task automatic write_word(input string name, input harness_pkg::addr_t a,
                              input harness_pkg::word_t w);
        send_byte(harness_pkg::CMD_WRITE);
        send_byte(a);
        send_byte(w[31:24]);  // MSB first
        send_byte(w[23:16]);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
        expect_reply(name, harness_pkg::ACK_BYTE, REPLY_CYCLES);
        shadow[a] = w;
    endtask

    task automatic read_check(input string name, input harness_pkg::addr_t a);
        harness_pkg::byte_t b;
        harness_pkg::word_t act;
        bit                 got;
        act = '0;
        send_byte(harness_pkg::CMD_READ);
        send_byte(a);
        for (int i = 0; i < 4; i++) begin
            get_byte(b, got, REPLY_CYCLES);
            if (!got) fail_run($sformatf("%s: read of %02h returned %0d of 4 bytes", name, a, i));
            act = {act[23:0], b};
        end
        check_word($sformatf("%s[%02h]", name, a), shadow[a], act);
    endtask

    task automatic load_program(input string name);
        for (int i = 0; i < prog_q.size(); i++) begin
            write_word(name, harness_pkg::addr_t'(i), prog_q[i]);
        end
    endtask

    task automatic run_program(input string name);
        harness_pkg::word_t expect_img [harness_pkg::MEM_WORDS];
        if (!ref_run(shadow, expect_img)) begin
            fail_run($sformatf("%s: the reference model did not halt", name));
        end else begin
            send_byte(harness_pkg::CMD_RUN);
            expect_reply(name, harness_pkg::HALT_BYTE, RUN_CYCLES);
            shadow = expect_img;
        end
    endtask

    // Samples the reply line at mid-bit on falling edges
    initial begin : uart_monitor
        harness_pkg::byte_t b;
        @(posedge arst_n);
        forever begin
            @(negedge sys_clk);
            if (uart_tx === 1'b0) begin
                repeat (harness_pkg::CLKS_PER_BIT / 2) @(negedge sys_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (harness_pkg::CLKS_PER_BIT) @(negedge sys_clk);
                    b[i] = uart_tx;
                end
                repeat (harness_pkg::CLKS_PER_BIT) @(negedge sys_clk);
                if (uart_tx !== 1'b1) fail_run("The reply byte had no stop bit");
                else rx_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        fail_run("Watchdog expired, the run timed out");
    end

    initial begin : run_tests
        harness_pkg::byte_t b;
        harness_pkg::addr_t a;
        harness_pkg::addr_t wr_addr [N_RAND_WR];
        logic [15:0]        imm;
        bit                 got;
        int                 op;
        uart_rx = 1'b1;
        void'($urandom(32'ha361_e824));
        shadow = '{default: '0};
        @(posedge arst_n);
        repeat (4) @(posedge sys_clk);

        send_byte(harness_pkg::CMD_ID);
        expect_reply("id", harness_pkg::CORE_ID, REPLY_CYCLES);

        for (int i = 0; i < N_RAND_WR; i++) begin
            wr_addr[i] = harness_pkg::addr_t'(8'h80 + $urandom_range(0, 127));
            write_word("rand_write", wr_addr[i], $urandom());
        end
        for (int i = 0; i < N_RAND_WR; i++) read_check("rand_read", wr_addr[i]);

        // Sums the word at 42 into 41 while the counter at 40 runs down
        write_word("loop_data", 8'h42, $urandom());
        prog_q.delete();
        prog_q.push_back(instr(harness_pkg::OP_LDI, 16'h0000));
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0041));
        prog_q.push_back(instr(harness_pkg::OP_LDI, 16'($urandom_range(3, 10))));
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0040));
        prog_q.push_back(instr(harness_pkg::OP_LD, 16'h0041));
        prog_q.push_back(instr(harness_pkg::OP_ADD, 16'h0042));
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0041));
        prog_q.push_back(instr(harness_pkg::OP_LD, 16'h0040));
        prog_q.push_back(instr(harness_pkg::OP_ADDI, 16'hFFFF));  // Counter minus one
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0040));
        prog_q.push_back(instr(harness_pkg::OP_BNZ, 16'h0004));
        prog_q.push_back(instr(harness_pkg::OP_LD, 16'h0041));
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0043));
        prog_q.push_back(instr(harness_pkg::OP_HALT, 16'h0000));
        load_program("loop_load");
        run_program("loop_run");
        for (int k = 0; k < 4; k++) read_check("loop_result", harness_pkg::addr_t'(8'h40 + k));

        // Straight-line program over the words at 50 to 57
        for (int k = 0; k < 8; k++) begin
            write_word("line_data", harness_pkg::addr_t'(8'h50 + k), $urandom());
        end
        prog_q.delete();
        prog_q.push_back(instr(harness_pkg::OP_LDI, 16'($urandom())));
        for (int k = 1; k < LINE_LEN - 1; k++) begin
            op  = $urandom_range(0, 3);
            a   = harness_pkg::addr_t'(8'h50 + $urandom_range(0, 7));
            imm = 16'($urandom());
            case (op)
                0:       prog_q.push_back(instr(harness_pkg::OP_LDI, imm));
                1:       prog_q.push_back(instr(harness_pkg::OP_ADDI, imm));
                2:       prog_q.push_back(instr(harness_pkg::OP_ADD, {8'h00, a}));
                default: prog_q.push_back(instr(harness_pkg::OP_ST, {8'h00, a}));
            endcase
        end
        prog_q.push_back(instr(harness_pkg::OP_HALT, 16'h0000));
        load_program("line_load");
        run_program("line_run");
        for (int k = 0; k < 8; k++) read_check("line_result", harness_pkg::addr_t'(8'h50 + k));

        send_byte(8'h7E);
        get_byte(b, got, REPLY_CYCLES);
        if (got) fail_run($sformatf("Unknown command 7E got the reply byte %02h", b));
        send_byte(harness_pkg::CMD_ID);
        expect_reply("id_after_unknown", harness_pkg::CORE_ID, REPLY_CYCLES);

        // The store after the bad opcode must not happen
        write_word("undef_data", 8'h62, $urandom());
        prog_q.delete();
        prog_q.push_back(instr(harness_pkg::OP_LDI, 16'($urandom())));
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0060));
        prog_q.push_back(instr(harness_pkg::OP_ADDI, 16'($urandom())));
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0061));
        prog_q.push_back(32'hEE00_0000);
        prog_q.push_back(instr(harness_pkg::OP_ST, 16'h0062));
        prog_q.push_back(instr(harness_pkg::OP_HALT, 16'h0000));
        load_program("undef_load");
        run_program("undef_run");
        for (int k = 0; k < 3; k++) read_check("undef_result", harness_pkg::addr_t'(8'h60 + k));

        repeat (REPLY_CYCLES) @(negedge sys_clk);
        if (rx_q.size() != 0) begin
            fail_run($sformatf("The DUT sent %0d reply bytes that were not expected", rx_q.size()));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- verilog.f
common/harness_pkg.sv
controller/uart_rx.sv
controller/uart_tx.sv
controller/harness_mem.sv
controller/harness_controller.sv
logic/acc_core.sv
logic/harness_top.sv
sim/tb_clock.sv
sim/tb_harness.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_harness
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
